// ==== include/core_mdu_consts.svh ====
// Multiply/divide unit sizing constants
// Register and word widths, multiplier unroll, iteration counts

`ifndef CORE_MDU_CONSTS_SVH
`define CORE_MDU_CONSTS_SVH

`define MDU_XLEN        64  // Register width
`define MDU_WLEN        32  // Word operation width

// Multiplier bits retired per cycle, must divide 32
`define MDU_MUL_UNROLL  4

`define MDU_MUL_ITER    (`MDU_XLEN / `MDU_MUL_UNROLL)
`define MDU_MUL_ITER_W  (`MDU_WLEN / `MDU_MUL_UNROLL)
`define MDU_DIV_ITER    `MDU_XLEN
`define MDU_DIV_ITER_W  `MDU_WLEN

`endif

// ==== source/core_mdu_pkg.sv ====
// Multiply/divide unit types
// Register and product values, operation encoding, pipeline request

package core_mdu_pkg;

    // ----------------------------------------
    // Data values
    // ----------------------------------------

    typedef logic [63:0]  xlen_t;   // One register
    typedef logic [127:0] dxlen_t;  // Full product

    // ----------------------------------------
    // Operations
    // ----------------------------------------

    typedef enum logic [2:0] {
        MDU_MUL    = 3'd0,  // Low half
        MDU_MULH   = 3'd1,  // High half, signed x signed
        MDU_MULHSU = 3'd2,  // High half, signed x unsigned
        MDU_MULHU  = 3'd3,  // High half, unsigned x unsigned
        MDU_DIV    = 3'd4,
        MDU_DIVU   = 3'd5,
        MDU_REM    = 3'd6,
        MDU_REMU   = 3'd7
    } mdu_op_e;

    // Request from the execute stage, 132 bits
    typedef struct packed {
        mdu_op_e op;
        logic    word;  // 32-bit variant
        xlen_t   rs1;
        xlen_t   rs2;
    } mdu_req_t;

endpackage

// ==== source/core_mdu_mul.sv ====
// Iterative unsigned shift-add multiplier
// Retires MDU_MUL_UNROLL multiplier bits per cycle into a double-width product

`timescale 1ns/10ps
`include "core_mdu_consts.svh"

module core_mdu_mul (
    input  logic                  g_clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  start,
    input  logic                  word,
    input  core_mdu_pkg::xlen_t   a,
    input  core_mdu_pkg::xlen_t   b,
    output logic                  done,
    output core_mdu_pkg::dxlen_t  product
);

    import core_mdu_pkg::*;

    localparam int CNT_W = $clog2(`MDU_MUL_ITER + 1);

    logic             busy_q;
    logic             done_q;
    logic [CNT_W-1:0] cnt_q;     // Iterations left
    dxlen_t           mcand_q;   // Multiplicand, moves up each cycle
    xlen_t            mplier_q;  // Multiplier, moves down each cycle
    dxlen_t           acc_q;
    dxlen_t           partial;

    // ----------------------------------------
    // Partial product for this cycle
    // ----------------------------------------

    always_comb begin
        partial = '0;
        for (int i = 0; i < `MDU_MUL_UNROLL; i++) begin
            if (mplier_q[i]) begin
                partial = partial + (mcand_q << i);
            end
        end
    end

    // Control
    always_ff @(posedge g_clk) begin
        if (!rst_n || flush) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= word ? CNT_W'(`MDU_MUL_ITER_W) : CNT_W'(`MDU_MUL_ITER);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin  // Last step
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (start) begin
            mcand_q  <= {{`MDU_XLEN{1'b0}}, a};
            mplier_q <= b;
            acc_q    <= '0;
        end else if (busy_q) begin
            acc_q    <= acc_q + partial;
            mcand_q  <= mcand_q << `MDU_MUL_UNROLL;
            mplier_q <= mplier_q >> `MDU_MUL_UNROLL;
        end
    end

    assign done    = done_q;
    assign product = acc_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    a_done_pulse: assert property (@(posedge g_clk) disable iff (!rst_n) done_q |=> !done_q);
    a_no_restart: assert property (@(posedge g_clk) disable iff (!rst_n) start |-> !busy_q);

endmodule

// ==== source/core_mdu_div.sv ====
// Iterative unsigned restoring divider
// One quotient bit per cycle, quotient and remainder out together

`timescale 1ns/10ps
`include "core_mdu_consts.svh"

module core_mdu_div (
    input  logic                 g_clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 start,
    input  logic                 word,
    input  core_mdu_pkg::xlen_t  dividend,
    input  core_mdu_pkg::xlen_t  divisor,
    output logic                 done,
    output core_mdu_pkg::xlen_t  quotient,
    output core_mdu_pkg::xlen_t  remainder
);

    import core_mdu_pkg::*;

    localparam int CNT_W = $clog2(`MDU_DIV_ITER + 1);

    logic               busy_q;
    logic               done_q;
    logic [CNT_W-1:0]   cnt_q;
    xlen_t              dq_q;     // Dividend bits out at top, quotient bits in at bottom
    xlen_t              rem_q;    // Partial remainder
    xlen_t              dvsr_q;
    logic [`MDU_XLEN:0]   shifted;
    logic [`MDU_XLEN+1:0] diff;
    logic               q_bit;

    // ----------------------------------------
    // One restoring step
    // ----------------------------------------

    always_comb begin
        shifted = {rem_q, dq_q[`MDU_XLEN-1]};
        diff    = {1'b0, shifted} - {2'b00, dvsr_q};
        q_bit   = !diff[`MDU_XLEN+1];  // No borrow, keep difference
    end

    // Control
    always_ff @(posedge g_clk) begin
        if (!rst_n || flush) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= word ? CNT_W'(`MDU_DIV_ITER_W) : CNT_W'(`MDU_DIV_ITER);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (start) begin
            // Word dividend sits in the top half so its MSB goes first
            dq_q   <= word ? {dividend[`MDU_WLEN-1:0], {(`MDU_XLEN-`MDU_WLEN){1'b0}}}
                           : dividend;
            rem_q  <= '0;
            dvsr_q <= divisor;
        end else if (busy_q) begin
            rem_q <= q_bit ? diff[`MDU_XLEN-1:0] : shifted[`MDU_XLEN-1:0];
            dq_q  <= {dq_q[`MDU_XLEN-2:0], q_bit};
        end
    end

    // Zero divisor gives all ones and the dividend back
    assign done      = done_q;
    assign quotient  = dq_q;
    assign remainder = rem_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    a_done_pulse: assert property (@(posedge g_clk) disable iff (!rst_n) done_q |=> !done_q);
    a_no_restart: assert property (@(posedge g_clk) disable iff (!rst_n) start |-> !busy_q);

endmodule

// ==== source/core_pipe_exec_mdu.sv ====
// Execute-stage multiply/divide unit
// Request decode, operand signs, FSM sequencing of multiplier and divider,
// result sign fix-up and selection

`timescale 1ns/10ps
`include "core_mdu_consts.svh"

module core_pipe_exec_mdu (
    input  logic                    g_clk,
    input  logic                    rst_n,
    input  logic                    flush,   // Abandon current operation
    input  logic                    valid,
    input  core_mdu_pkg::mdu_req_t  req,
    output logic                    ready,   // One-cycle result strobe
    output core_mdu_pkg::xlen_t     rd
);

    import core_mdu_pkg::*;

    typedef enum logic [1:0] {
        MDU_IDLE,
        MDU_MUL_RUN,
        MDU_DIV_RUN,
        MDU_DONE
    } mdu_state_e;

    mdu_state_e state_q;
    logic       mul_start_q, div_start_q;
    logic       mul_done, div_done;
    dxlen_t     mul_product;
    xlen_t      div_quotient, div_remainder;

    mdu_op_e    op_q;
    logic       word_q;
    logic       neg1_q, neg2_q;      // Operand signs
    xlen_t      mag1_q, mag2_q;      // Operand magnitudes
    xlen_t      rd_q;

    logic       accept, is_mul, s1_signed, s2_signed;
    xlen_t      op1, op2;
    dxlen_t     prod_s;
    xlen_t      quo_s, rem_s, res_sel;

    // Word operands from low half, sign or zero extended
    function automatic xlen_t ext_operand(input xlen_t v, input logic sgn, input logic wd);
        logic fill;
        fill = sgn && v[`MDU_WLEN-1];
        return wd ? {{(`MDU_XLEN-`MDU_WLEN){fill}}, v[`MDU_WLEN-1:0]} : v;
    endfunction

    // ----------------------------------------
    // Request decode
    // ----------------------------------------

    always_comb begin
        accept    = (state_q == MDU_IDLE) && valid;
        is_mul    = req.op inside {MDU_MUL, MDU_MULH, MDU_MULHSU, MDU_MULHU};
        s1_signed = req.op inside {MDU_MULH, MDU_MULHSU, MDU_DIV, MDU_REM};
        s2_signed = req.op inside {MDU_MULH, MDU_DIV, MDU_REM};
        op1       = ext_operand(req.rs1, s1_signed, req.word);
        op2       = ext_operand(req.rs2, s2_signed, req.word);
    end

    // FSM
    always_ff @(posedge g_clk) begin
        if (!rst_n || flush) begin
            state_q     <= MDU_IDLE;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
        end else begin
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
            case (state_q)
                MDU_IDLE: if (valid) begin
                    state_q     <= is_mul ? MDU_MUL_RUN : MDU_DIV_RUN;
                    mul_start_q <= is_mul;
                    div_start_q <= !is_mul;
                end
                MDU_MUL_RUN: if (mul_done) state_q <= MDU_DONE;
                MDU_DIV_RUN: if (div_done) state_q <= MDU_DONE;
                default:     state_q <= MDU_IDLE;  // Ready cycle
            endcase
        end
    end

    // Operand capture and result register
    always_ff @(posedge g_clk) begin
        if (accept) begin
            op_q   <= req.op;
            word_q <= req.word;
            neg1_q <= s1_signed && op1[`MDU_XLEN-1];
            neg2_q <= s2_signed && op2[`MDU_XLEN-1];
            mag1_q <= (s1_signed && op1[`MDU_XLEN-1]) ? -op1 : op1;
            mag2_q <= (s2_signed && op2[`MDU_XLEN-1]) ? -op2 : op2;
        end
        if (mul_done || div_done) begin
            rd_q <= res_sel;
        end
    end

    // ----------------------------------------
    // Result signs and selection
    // ----------------------------------------

    always_comb begin
        prod_s = (neg1_q ^ neg2_q) ? -mul_product : mul_product;
        // Zero divisor keeps all ones quotient
        quo_s  = ((neg1_q ^ neg2_q) && (mag2_q != '0)) ? -div_quotient : div_quotient;
        rem_s  = neg1_q ? -div_remainder : div_remainder;  // Follows dividend
        if (state_q == MDU_MUL_RUN) begin
            res_sel = (op_q == MDU_MUL) ? prod_s[`MDU_XLEN-1:0]
                                        : prod_s[2*`MDU_XLEN-1:`MDU_XLEN];
        end else begin
            res_sel = (op_q inside {MDU_DIV, MDU_DIVU}) ? quo_s : rem_s;
        end
        if (word_q) begin
            res_sel = {{(`MDU_XLEN-`MDU_WLEN){res_sel[`MDU_WLEN-1]}}, res_sel[`MDU_WLEN-1:0]};
        end
    end

    core_mdu_mul core_mdu_mul_inst (
        .g_clk   (g_clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .start   (mul_start_q),
        .word    (word_q),
        .a       (mag1_q),
        .b       (mag2_q),
        .done    (mul_done),
        .product (mul_product)
    );

    core_mdu_div core_mdu_div_inst (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .start     (div_start_q),
        .word      (word_q),
        .dividend  (mag1_q),
        .divisor   (mag2_q),
        .done      (div_done),
        .quotient  (div_quotient),
        .remainder (div_remainder)
    );

    assign ready = (state_q == MDU_DONE);
    assign rd    = rd_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Pipeline holds the request until it sees ready
    a_ready_valid: assert property (@(posedge g_clk) disable iff (!rst_n) ready |-> valid);

    a_word_ops: assert property (@(posedge g_clk) disable iff (!rst_n)
        (accept && req.word) |-> (req.op inside {MDU_MUL, MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU}));

endmodule

// ==== testbench/tb_core_mdu.sv ====
// Testbench for the execute-stage multiply/divide unit
// Reads tests from the stimulus file, drives requests, checks rd, latency and flush

`timescale 1ns/10ps

module tb_core_mdu;

    import core_mdu_pkg::*;

    localparam string STIM_FILE       = "testbench/mdu_stim.txt";
    localparam int    SEED            = 32'h1512_a5eb;
    localparam int    DRIVE_DELAY     = 1;    // ns after the rising edge
    localparam int    CYCLES_PER_TEST = 80;
    localparam int    TIMEOUT_MARGIN  = 200;  // Reset and slack, in cycles
    localparam int    READY_LIMIT     = 100;

    logic     g_clk;
    logic     rst_n;
    logic     flush;
    logic     valid;
    mdu_req_t req;
    logic     ready;
    xlen_t    rd;

    // Test table from the stimulus file
    string    names[$];
    mdu_op_e  ops[$];
    logic     words[$];
    logic     flushes[$];
    xlen_t    rs1s[$];
    xlen_t    rs2s[$];
    xlen_t    exp_rds[$];

    int       n_tests;
    int       n_fail;
    int       n_errors;
    logic     loaded;
    logic     test_ok;

    always #5 g_clk = ~g_clk;

    core_pipe_exec_mdu core_pipe_exec_mdu_inst (
        .g_clk (g_clk),
        .rst_n (rst_n),
        .flush (flush),
        .valid (valid),
        .req   (req),
        .ready (ready),
        .rd    (rd)
    );

    // ----------------------------------------
    // Expected values and checks
    // ----------------------------------------

    // Edges from accept to the ready cycle
    function automatic int expected_latency(input mdu_op_e op, input logic word);
        logic is_mul;
        is_mul = (op == MDU_MUL) || (op == MDU_MULH) || (op == MDU_MULHSU) || (op == MDU_MULHU);
        if (is_mul) begin
            return word ? 10 : 18;
        end
        return word ? 34 : 66;
    endfunction

    function automatic logic decode_op(input logic [8*8-1:0] nm, output mdu_op_e op);
        decode_op = 1'b1;
        op        = MDU_MUL;
        case (nm)
            "MUL":    op = MDU_MUL;
            "MULH":   op = MDU_MULH;
            "MULHSU": op = MDU_MULHSU;
            "MULHU":  op = MDU_MULHU;
            "DIV":    op = MDU_DIV;
            "DIVU":   op = MDU_DIVU;
            "REM":    op = MDU_REM;
            "REMU":   op = MDU_REMU;
            default:  decode_op = 1'b0;
        endcase
    endfunction

    task automatic check_rd(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0s: rd expected %h, actual %h", name, expected, actual);
            n_errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_latency(input string name, input mdu_op_e op, input logic word,
                                 input int actual);
        int expected;
        expected = expected_latency(op, word);
        if (actual != expected) begin
            $display("[ERROR] %0s: latency expected %0d, actual %0d", name, expected, actual);
            n_errors++;
            test_ok = 1'b0;
        end
    endtask

    // ----------------------------------------
    // Stimulus file
    // ----------------------------------------

    task automatic load_tests();
        int              fd;
        int              code;
        int              ch;
        int              w_i;
        int              f_i;
        logic [8*32-1:0] tok;
        logic [8*8-1:0]  op_v;
        xlen_t           a;
        xlen_t           b;
        xlen_t           e;
        mdu_op_e         op;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open stimulus file %0s", STIM_FILE);
            n_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) break;
            if (tok == "#") begin  // Comment line
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%s %d %d %h %h %h", op_v, w_i, f_i, a, b, e);
                if (code != 6) begin
                    $display("Malformed stimulus line for test %0s", tok);
                    n_errors++;
                    break;
                end
                if (!decode_op(op_v, op)) begin
                    $display("Unknown operation %0s in test %0s", op_v, tok);
                    n_errors++;
                end else begin
                    names.push_back($sformatf("%0s", tok));
                    ops.push_back(op);
                    words.push_back(w_i != 0);
                    flushes.push_back(f_i != 0);
                    rs1s.push_back(a);
                    rs2s.push_back(b);
                    exp_rds.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    // ----------------------------------------
    // One test
    // ----------------------------------------

    task automatic run_test(input int idx);
        int    cycles;
        int    gap;
        logic  saw_ready;
        string nm;
        nm        = names[idx];
        test_ok   = 1'b1;
        cycles    = 0;
        saw_ready = 1'b0;
        gap       = $urandom % 4;  // Zero keeps valid high back to back
        if (gap > 0) begin
            valid = 1'b0;
            repeat (gap) begin
                @(posedge g_clk);
                #DRIVE_DELAY;
            end
        end
        valid    = 1'b1;
        req.op   = ops[idx];
        req.word = words[idx];
        req.rs1  = rs1s[idx];
        req.rs2  = rs2s[idx];
        @(posedge g_clk);  // Idle unit accepts here
        #DRIVE_DELAY;
        if (flushes[idx]) begin
            repeat (3) begin
                @(posedge g_clk);
                #DRIVE_DELAY;
                saw_ready |= ready;
            end
            flush = 1'b1;
            valid = 1'b0;
            @(posedge g_clk);
            #DRIVE_DELAY;
            flush = 1'b0;
            repeat (expected_latency(ops[idx], words[idx]) + 4) begin
                @(posedge g_clk);
                #DRIVE_DELAY;
                saw_ready |= ready;
            end
            if (saw_ready) begin
                $display("%0s: ready appeared for a flushed operation", nm);
                n_errors++;
                test_ok = 1'b0;
            end
            $display("test %0s: %0s, flushed", nm, test_ok ? "ok" : "FAILED");
        end else begin
            while (!ready && cycles < READY_LIMIT) begin
                @(posedge g_clk);
                #DRIVE_DELAY;
                cycles++;
            end
            if (!ready) begin
                $display("%0s: no ready within %0d cycles", nm, READY_LIMIT);
                n_errors++;
                test_ok = 1'b0;
            end else begin
                check_rd(nm, exp_rds[idx], rd);
                check_latency(nm, ops[idx], words[idx], cycles);
            end
            @(posedge g_clk);
            #DRIVE_DELAY;
            if (ready) begin
                $display("%0s: ready stayed high for more than one cycle", nm);
                n_errors++;
                test_ok = 1'b0;
            end
            $display("test %0s: %0s, rd %h after %0d cycles", nm,
                     test_ok ? "ok" : "FAILED", rd, cycles);
        end
        if (!test_ok) n_fail++;
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------

    initial begin
        g_clk    = 1'b0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        valid    = 1'b0;
        req      = '0;
        n_tests  = 0;
        n_fail   = 0;
        n_errors = 0;
        loaded   = 1'b0;
        void'($urandom(SEED));
        load_tests();
        n_tests = names.size();
        loaded  = 1'b1;
        repeat (3) @(posedge g_clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        valid = 1'b0;
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, n_tests - n_fail, n_fail, n_errors);
        if (n_errors == 0 && n_tests > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (loaded === 1'b1);
        repeat (n_tests * CYCLES_PER_TEST + TIMEOUT_MARGIN) @(posedge g_clk);
        $display("Timeout: tests did not finish within %0d cycles",
                 n_tests * CYCLES_PER_TEST + TIMEOUT_MARGIN);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== testbench/mdu_stim.txt ====
# name op word flush rs1 rs2 expected_rd
# word and flush are 0 or 1, values are 64-bit hex, expected_rd is unused on flush lines
mul_small    MUL    0 0 0000000000000007 0000000000000006 000000000000002A
mul_neg      MUL    0 0 FFFFFFFFFFFFFFFD 0000000000000005 FFFFFFFFFFFFFFF1
mulh_neg_big MULH   0 0 C000000000000000 0000000000000010 FFFFFFFFFFFFFFFC
mulhu_max    MULHU  0 0 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFE
mulhsu_pos   MULHSU 0 0 0000000000000002 8000000000000000 0000000000000001
mulhsu_neg   MULHSU 0 0 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
div_neg_pos  DIV    0 0 FFFFFFFFFFFFFFEC 0000000000000003 FFFFFFFFFFFFFFFA
rem_neg_pos  REM    0 0 FFFFFFFFFFFFFFEC 0000000000000003 FFFFFFFFFFFFFFFE
rem_pos_neg  REM    0 0 0000000000000014 FFFFFFFFFFFFFFFD 0000000000000002
divu_big     DIVU   0 0 FFFFFFFFFFFFFFEC 0000000000000003 555555555555554E
remu_big     REMU   0 0 FFFFFFFFFFFFFFEC 0000000000000003 0000000000000002
div_ovf      DIV    0 0 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000
rem_ovf      REM    0 0 8000000000000000 FFFFFFFFFFFFFFFF 0000000000000000
div_zero     DIV    0 0 FFFFFFFFFFFFFFF9 0000000000000000 FFFFFFFFFFFFFFFF
rem_zero     REM    0 0 FFFFFFFFFFFFFFF9 0000000000000000 FFFFFFFFFFFFFFF9
divu_zero    DIVU   0 0 0000000000001234 0000000000000000 FFFFFFFFFFFFFFFF
remu_zero    REMU   0 0 0000000000001234 0000000000000000 0000000000001234
mulw         MUL    1 0 DEADBEEF00010000 123456780000FFFF FFFFFFFFFFFF0000
divw         DIV    1 0 12345678FFFFFFEC AAAAAAAA00000003 FFFFFFFFFFFFFFFA
divuw        DIVU   1 0 00000001FFFFFFEC 0000000000000003 000000005555554E
remw         REM    1 0 00000000FFFFFFEC FFFFFFFF00000003 FFFFFFFFFFFFFFFE
remuw        REMU   1 0 FFFFFFFFFFFFFFEC 0000000000000003 0000000000000002
divw_ovf     DIV    1 0 0000000080000000 00000000FFFFFFFF FFFFFFFF80000000
flush_mul    MULH   0 1 7FFFFFFFFFFFFFFF 0000000000000003 0000000000000000
mulhu_after  MULHU  0 0 0000000100000000 0000000100000000 0000000000000001
flush_div    DIV    0 1 FFFFFFFFFFFFFF00 0000000000000007 0000000000000000
divu_after   DIVU   0 0 0000000000000064 0000000000000007 000000000000000E

// ==== flist.f ====
+incdir+include
source/core_mdu_pkg.sv
source/core_mdu_mul.sv
source/core_mdu_div.sv
source/core_pipe_exec_mdu.sv
testbench/tb_core_mdu.sv

// ==== Makefile ====
# Verilator build and run of the multiply/divide unit testbench

VERILATOR ?= verilator
TOP       ?= tb_core_mdu
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
